/* hw/lcdPixelPkg.sv */
package lcdPixelPkg;

	// One panel pixel as shifted out on SDA, red first
	typedef struct packed
	{
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565T;

	// Even pixel goes left, odd pixel goes right
	typedef struct packed
	{
		rgb565T even;
		rgb565T odd;
	} pixelPairT;

	// Incoming pixel; in RGB mode y is green, u is blue and v is red
	typedef struct packed
	{
		logic       isRgb;
		logic [7:0] y;     // Y or G
		logic [7:0] u;     // U or B
		logic [7:0] v;     // V or R
	} colorInT;

endpackage

/* hw/lcdLinkPkg.sv */
package lcdLinkPkg;

	localparam int CMD_BITS = 8;   // Bits per command byte
	localparam int PIX_BITS = 16;  // Bits per RGB565 pixel

	// Command path entry, isData drives the DC pin
	typedef struct packed
	{
		logic                isData;
		logic [CMD_BITS-1:0] data;
	} dbiCmdT;

endpackage

/* hw/pixelPairer.sv */
`timescale 1ns/1ns

module pixelPairer
	import lcdPixelPkg::*;
(
	input  logic      clock,
	input  logic      rstN,
	input  logic      pixValid,
	input  colorInT   pixIn,
	output logic      pixReady,
	output logic      pixCyc,
	output logic      pixStb,
	output logic      pixWe,
	output pixelPairT pixDat,
	input  logic      pixAck
);

	colorInT            inReg;         // Accepted pixel
	logic               inValid;
	rgb565T             rgbReg;        // Converted pixel
	logic               rgbValid;
	rgb565T             evenHold;      // Left pixel waiting for its partner
	logic               oddNext;       // Next converted pixel closes a pair
	logic               writePending;
	logic               advance;
	logic signed [10:0] uOff;
	logic signed [10:0] vOff;
	logic signed [10:0] greenS;
	logic signed [10:0] redS;
	logic signed [10:0] blueS;
	logic [7:0]         redC;
	logic [7:0]         greenC;
	logic [7:0]         blueC;
	rgb565T             rgbNext;

	function automatic logic [7:0] clamp8(input logic signed [10:0] value);
		if (value < 0)
			return 8'd0;
		else if (value > 11'sd255)
			return 8'd255;
		else
			return value[7:0];
	endfunction

	// Pipeline moves unless a pair write is still waiting for ack
	assign advance  = !writePending || pixAck;
	assign pixReady = advance;
	assign pixCyc   = writePending;
	assign pixStb   = writePending;
	assign pixWe    = writePending;

	always_comb
	begin
		uOff   = $signed({3'b000, inReg.u}) - 11'sd128;
		vOff   = $signed({3'b000, inReg.v}) - 11'sd128;
		greenS = $signed({3'b000, inReg.y}) - (uOff >>> 1) - (vOff >>> 1);
		redS   = greenS + (vOff <<< 1);
		blueS  = greenS + (uOff <<< 1);
		redC   = clamp8(redS);
		greenC = clamp8(greenS);
		blueC  = clamp8(blueS);
		if (inReg.isRgb)
		begin
			rgbNext.red   = inReg.v[7:3];
			rgbNext.green = inReg.y[7:2];
			rgbNext.blue  = inReg.u[7:3];
		end
		else
		begin
			rgbNext.red   = redC[7:3];
			rgbNext.green = greenC[7:2];
			rgbNext.blue  = blueC[7:3];
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			inValid      <= 1'b0;
			rgbValid     <= 1'b0;
			oddNext      <= 1'b0;
			writePending <= 1'b0;
		end
		else
		begin
			if (pixAck)
				writePending <= 1'b0;
			if (advance)
			begin
				inValid  <= pixValid;  // Accepted when ready is high
				rgbValid <= inValid;
				if (rgbValid)
				begin
					oddNext <= !oddNext;
					if (oddNext)
						writePending <= 1'b1;  // Strobe two clocks after accept
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			inReg  <= pixIn;
			rgbReg <= rgbNext;
			if (rgbValid && !oddNext)
				evenHold <= rgbReg;
			if (rgbValid && oddNext)
			begin
				pixDat.even <= evenHold;
				pixDat.odd  <= rgbReg;
			end
		end
	end

endmodule

/* hw/wbFifo.sv */
`timescale 1ns/1ns

module wbFifo
#(
	parameter type PayloadT = logic [7:0],
	parameter int  DEPTH    = 8
)
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    wCyc,
	input  logic    wStb,
	input  logic    wWe,
	input  PayloadT wDat,
	output logic    wAck,
	input  logic    rCyc,
	input  logic    rStb,
	output logic    rAck,
	output PayloadT rDat
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	PayloadT          mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;     // Entries held
	logic             doWrite;
	logic             doRead;

	// Ack only once per strobe; the master drops stb after seeing it
	assign doWrite = wCyc && wStb && wWe && !wAck && (count != CNT_W'(DEPTH));
	assign doRead  = rCyc && rStb && !rAck && (count != '0);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			wAck  <= 1'b0;
			rAck  <= 1'b0;
		end
		else
		begin
			wAck  <= doWrite;
			rAck  <= doRead;
			count <= count + CNT_W'(doWrite) - CNT_W'(doRead);
			if (doWrite)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doRead)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
		end
	end

	// Storage and read data
	always_ff @(posedge clock)
	begin
		if (doWrite)
			mem[wrPtr] <= wDat;
		if (doRead)
			rDat <= mem[rdPtr];  // Valid together with rAck
	end

endmodule

/* hw/dbiSerializer.sv */
`timescale 1ns/1ns

module dbiSerializer
	import lcdPixelPkg::*, lcdLinkPkg::*;
#(
	parameter int PANEL_WIDTH  = 240,
	parameter int PANEL_HEIGHT = 240
)
(
	input  logic        clock,
	input  logic        rstN,
	output logic        cmdCyc,
	output logic        cmdStb,
	input  logic        cmdAck,
	input  dbiCmdT      cmdDat,
	output logic        pixCyc,
	output logic        pixStb,
	input  logic        pixAck,
	input  pixelPairT   pixDat,
	output logic        sclL,
	output logic        sdaL,
	output logic        dcL,
	output logic        csNL,
	output logic        sclR,
	output logic        sdaR,
	output logic        dcR,
	output logic        csNR,
	output logic        resN,
	output logic [11:0] pixPosX,
	output logic [11:0] pixPosY,
	output logic        frameEnd
);

	typedef enum logic [1:0] { stIdle, stCmd, stPix } wordStateT;

	wordStateT           state;         // Kind of word on the wire
	logic [3:0]          bitCnt;
	logic [3:0]          lastBit;
	logic                phase;         // High half of the bit
	logic                sclQ;
	logic                csNQ;
	logic                dcQ;
	logic                resNQ;
	logic                cmdStbQ;
	logic                pixStbQ;
	logic [PIX_BITS-1:0] shiftL;
	logic [PIX_BITS-1:0] shiftR;
	dbiCmdT              cmdHold;       // Entry acked while a word was busy
	logic                cmdHoldValid;
	pixelPairT           pixHold;
	logic                pixHoldValid;
	logic                wordFree;
	logic                wordDone;
	logic                loadCmd;
	logic                loadPix;
	dbiCmdT              cmdWord;
	pixelPairT           pairWord;

	assign wordDone = (state != stIdle) && phase && (bitCnt == lastBit);
	assign wordFree = (state == stIdle) || wordDone;

	// Next word choice, commands first
	always_comb
	begin
		loadCmd  = wordFree && (cmdHoldValid || cmdAck);
		loadPix  = wordFree && !loadCmd && (pixHoldValid || pixAck);
		cmdWord  = cmdHoldValid ? cmdHold : cmdDat;
		pairWord = pixHoldValid ? pixHold : pixDat;
	end

	always_ff @(posedge clock)
	begin
		resNQ <= rstN;  // Panel leaves reset one clock late
		if (!rstN)
		begin
			state        <= stIdle;
			bitCnt       <= '0;
			lastBit      <= '0;
			phase        <= 1'b0;
			sclQ         <= 1'b0;
			csNQ         <= 1'b1;
			dcQ          <= 1'b0;
			cmdStbQ      <= 1'b0;
			pixStbQ      <= 1'b0;
			cmdHoldValid <= 1'b0;
			pixHoldValid <= 1'b0;
			pixPosX      <= '0;
			pixPosY      <= '0;
			frameEnd     <= 1'b0;
		end
		else
		begin
			frameEnd <= 1'b0;

			if (cmdAck)
				cmdStbQ <= 1'b0;
			else if (!cmdStbQ && !cmdHoldValid)
				cmdStbQ <= 1'b1;
			if (pixAck)
				pixStbQ <= 1'b0;
			else if (!pixStbQ && !pixHoldValid)
				pixStbQ <= 1'b1;

			if (loadCmd && cmdHoldValid)
				cmdHoldValid <= 1'b0;
			else if (cmdAck && !loadCmd)
				cmdHoldValid <= 1'b1;
			if (loadPix && pixHoldValid)
				pixHoldValid <= 1'b0;
			else if (pixAck && !loadPix)
				pixHoldValid <= 1'b1;

			if (loadCmd || loadPix)
			begin
				state   <= loadCmd ? stCmd : stPix;
				lastBit <= loadCmd ? 4'(CMD_BITS - 1) : 4'(PIX_BITS - 1);
				dcQ     <= loadCmd ? cmdWord.isData : 1'b1;
				bitCnt  <= '0;
				phase   <= 1'b0;
				sclQ    <= 1'b0;
				csNQ    <= 1'b0;
			end
			else if (wordDone)
			begin
				state <= stIdle;
				phase <= 1'b0;
				sclQ  <= 1'b0;
				csNQ  <= 1'b1;
			end
			else if (state != stIdle)
			begin
				phase <= !phase;
				sclQ  <= !phase;  // Rises in the second clock of a bit
				if (phase)
					bitCnt <= bitCnt + 1'b1;
			end

			if (wordDone && (state == stPix))
			begin
				if (pixPosX == 12'(PANEL_WIDTH - 1))
				begin
					pixPosX <= '0;
					if (pixPosY == 12'(PANEL_HEIGHT - 1))
					begin
						pixPosY  <= '0;
						frameEnd <= 1'b1;
					end
					else
						pixPosY <= pixPosY + 1'b1;
				end
				else
					pixPosX <= pixPosX + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (cmdAck && !loadCmd)
			cmdHold <= cmdDat;
		if (pixAck && !loadPix)
			pixHold <= pixDat;

		if (loadCmd)
		begin
			shiftL <= {cmdWord.data, {(PIX_BITS - CMD_BITS){1'b0}}};
			shiftR <= {cmdWord.data, {(PIX_BITS - CMD_BITS){1'b0}}};
		end
		else if (loadPix)
		begin
			shiftL <= pairWord.even;
			shiftR <= pairWord.odd;
		end
		else if ((state != stIdle) && phase && !wordDone)
		begin
			shiftL <= shiftL << 1;  // MSB first
			shiftR <= shiftR << 1;
		end
	end

	assign cmdCyc = cmdStbQ;
	assign cmdStb = cmdStbQ;
	assign pixCyc = pixStbQ;
	assign pixStb = pixStbQ;
	assign sclL   = sclQ;
	assign sclR   = sclQ;
	assign sdaL   = shiftL[PIX_BITS-1];
	assign sdaR   = shiftR[PIX_BITS-1];
	assign dcL    = dcQ;
	assign dcR    = dcQ;
	assign csNL   = csNQ;
	assign csNR   = csNQ;
	assign resN   = resNQ;

endmodule

/* hw/lcdDbiPair.sv */
`timescale 1ns/1ns

module lcdDbiPair
	import lcdPixelPkg::*, lcdLinkPkg::*;
#(
	parameter int PANEL_WIDTH  = 240,
	parameter int PANEL_HEIGHT = 240,
	parameter int PIX_DEPTH    = 16,
	parameter int CMD_DEPTH    = 8
)
(
	input  logic        clock,
	input  logic        rstN,
	input  logic        pixValid,
	input  colorInT     pixIn,
	output logic        pixReady,
	input  logic        cmdCyc,
	input  logic        cmdStb,
	input  logic        cmdWe,
	input  dbiCmdT      cmdDat,
	output logic        cmdAck,
	output logic        sclL,
	output logic        sdaL,
	output logic        dcL,
	output logic        csNL,
	output logic        sclR,
	output logic        sdaR,
	output logic        dcR,
	output logic        csNR,
	output logic        resN,
	output logic [11:0] pixPosX,
	output logic [11:0] pixPosY,
	output logic        frameEnd
);

	logic      pairCyc;       // Producer to pixel buffer
	logic      pairStb;
	logic      pairWe;
	pixelPairT pairDat;
	logic      pairAck;
	logic      pixRdCyc;      // Pixel buffer to serializer
	logic      pixRdStb;
	logic      pixRdAck;
	pixelPairT pixRdDat;
	logic      cmdRdCyc;      // Command buffer to serializer
	logic      cmdRdStb;
	logic      cmdRdAck;
	dbiCmdT    cmdRdDat;

	pixelPairer pairer (
		.clock(clock), .rstN(rstN),
		.pixValid(pixValid), .pixIn(pixIn), .pixReady(pixReady),
		.pixCyc(pairCyc), .pixStb(pairStb), .pixWe(pairWe),
		.pixDat(pairDat), .pixAck(pairAck)
	);

	wbFifo #(.PayloadT(pixelPairT), .DEPTH(PIX_DEPTH)) pixFifo (
		.clock(clock), .rstN(rstN),
		.wCyc(pairCyc), .wStb(pairStb), .wWe(pairWe), .wDat(pairDat), .wAck(pairAck),
		.rCyc(pixRdCyc), .rStb(pixRdStb), .rAck(pixRdAck), .rDat(pixRdDat)
	);

	wbFifo #(.PayloadT(dbiCmdT), .DEPTH(CMD_DEPTH)) cmdFifo (
		.clock(clock), .rstN(rstN),
		.wCyc(cmdCyc), .wStb(cmdStb), .wWe(cmdWe), .wDat(cmdDat), .wAck(cmdAck),
		.rCyc(cmdRdCyc), .rStb(cmdRdStb), .rAck(cmdRdAck), .rDat(cmdRdDat)
	);

	dbiSerializer #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) serializer (
		.clock(clock), .rstN(rstN),
		.cmdCyc(cmdRdCyc), .cmdStb(cmdRdStb), .cmdAck(cmdRdAck), .cmdDat(cmdRdDat),
		.pixCyc(pixRdCyc), .pixStb(pixRdStb), .pixAck(pixRdAck), .pixDat(pixRdDat),
		.sclL(sclL), .sdaL(sdaL), .dcL(dcL), .csNL(csNL),
		.sclR(sclR), .sdaR(sdaR), .dcR(dcR), .csNR(csNR),
		.resN(resN), .pixPosX(pixPosX), .pixPosY(pixPosY), .frameEnd(frameEnd)
	);

endmodule

/* tb/lcdDbiPair_checker.sv */
`timescale 1ns/1ns

module lcdDbiPair_checker
(
	input logic clock,
	input logic rstN,
	input logic sclL,
	input logic sclR,
	input logic csNL,
	input logic csNR,
	input logic dcL,
	input logic wordDone,
	input logic cmdCyc,
	input logic cmdStb,
	input logic cmdAck,
	input logic pixCyc,
	input logic pixStb,
	input logic pixAck
);

	int failures = 0;  // Assertion failures so far

	// The falling edge that ends a word comes with CS already rising
	sclInWord: assert property (@(posedge clock) disable iff (!rstN)
		$changed(sclL) |-> $past(!csNL))
		else
		begin
			failures++;
			$error("SCL toggled while the panels were deselected");
		end

	dcSteady: assert property (@(posedge clock) disable iff (!rstN)
		(!csNL && !wordDone) |=> $stable(dcL))
		else
		begin
			failures++;
			$error("DC changed inside a word");
		end

	// A read request stays up with its cycle until the buffer answers
	cmdStbCyc: assert property (@(posedge clock) disable iff (!rstN)
		(cmdStb && !cmdAck) |=> (cmdCyc && cmdStb))
		else
		begin
			failures++;
			$error("command read strobe or cycle dropped before ack");
		end

	pixStbCyc: assert property (@(posedge clock) disable iff (!rstN)
		(pixStb && !pixAck) |=> (pixCyc && pixStb))
		else
		begin
			failures++;
			$error("pixel read strobe or cycle dropped before ack");
		end

	idleAfterReset: assert property (@(posedge clock)
		$rose(rstN) |-> (csNL && csNR && !sclL && !sclR))
		else
		begin
			failures++;
			$error("link not idle in the first cycle after reset");
		end

endmodule

/* tb/lcdDbiPair_tb.sv */
`timescale 1ns/1ns

module lcdDbiPair_tb
	import lcdPixelPkg::*, lcdLinkPkg::*;
();

	localparam int PANEL_WIDTH  = 4;
	localparam int PANEL_HEIGHT = 2;
	localparam int PIX_N        = 10;
	localparam int CMD_N        = 4;
	localparam int TOTAL_PAIRS  = PIX_N;  // Two passes of PIX_N / 2 pairs
	localparam int LIMIT        = (2 * PIX_N + 2 * CMD_N) * 40 + 300;

	logic        clock;
	logic        rstN;
	logic        pixValid;
	colorInT     pixIn;
	logic        pixReady;
	logic        cmdCyc;
	logic        cmdStb;
	logic        cmdWe;
	dbiCmdT      cmdDat;
	logic        cmdAck;
	logic        sclL;
	logic        sdaL;
	logic        dcL;
	logic        csNL;
	logic        sclR;
	logic        sdaR;
	logic        dcR;
	logic        csNR;
	logic        resN;
	logic [11:0] pixPosX;
	logic [11:0] pixPosY;
	logic        frameEnd;

	// Entries are {isRgb, y or G, u or B, v or R}
	colorInT pixStim [PIX_N] = '{
		{1'b1, 8'h80, 8'h00, 8'hFF},
		{1'b1, 8'h34, 8'h56, 8'h12},
		{1'b1, 8'hFF, 8'hFF, 8'h00},
		{1'b1, 8'h40, 8'h20, 8'h80},
		{1'b0, 8'h80, 8'h80, 8'h80},
		{1'b0, 8'hFF, 8'hFF, 8'hFF},
		{1'b0, 8'h00, 8'h00, 8'h00},
		{1'b0, 8'h10, 8'h90, 8'h30},
		{1'b0, 8'h00, 8'hFF, 8'hFF},
		{1'b0, 8'hFF, 8'h00, 8'h00}
	};
	rgb565T pixExp [PIX_N] = '{16'hFC00, 16'h11AA, 16'h07FF, 16'h8204, 16'h8410,
		16'hFC1F, 16'h0400, 16'h018A, 16'h8010, 16'h7FEF};
	string pixTag [PIX_N] = '{"rgb red", "rgb mixed", "rgb cyan", "rgb dim", "yuv grey",
		"yuv clamp high", "yuv clamp low", "yuv red clamp", "yuv green clamp",
		"yuv green high"};
	dbiCmdT cmdStim [CMD_N] = '{{1'b0, 8'h2A}, {1'b1, 8'h00}, {1'b1, 8'hEF}, {1'b0, 8'h2C}};

	integer              seed = 50;
	int                  pixErrors = 0;
	int                  cmdErrors = 0;
	int                  posErrors = 0;
	int                  otherErrors = 0;
	int                  cycleCount;
	int                  pairCount = 0;
	int                  frameCount = 0;
	int                  nBits = 0;
	logic                sclPrev = 1'b0;
	logic                wordDc;
	logic                wordDcR;
	logic [PIX_BITS-1:0] curL;
	logic [PIX_BITS-1:0] curR;
	pixelPairT           pixQ [$];
	dbiCmdT              cmdQ [$];
	int                  cmdDoneMark [$];   // Pairs decoded when each command arrived
	int                  cmdWriteMark [$];  // Pairs decoded when each command was acked

	lcdDbiPair #(.PANEL_WIDTH(PANEL_WIDTH), .PANEL_HEIGHT(PANEL_HEIGHT)) dut (.*);

	bind dbiSerializer lcdDbiPair_checker linkChecks (
		.clock(clock), .rstN(rstN), .sclL(sclL), .sclR(sclR),
		.csNL(csNL), .csNR(csNR), .dcL(dcL), .wordDone(wordDone),
		.cmdCyc(cmdCyc), .cmdStb(cmdStb), .cmdAck(cmdAck),
		.pixCyc(pixCyc), .pixStb(pixStb), .pixAck(pixAck)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic checkPixel(input string name, input rgb565T expected, input rgb565T actual);
		if (actual !== expected)
		begin
			pixErrors++;
			$display("ERROR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkCmd(input string name, input dbiCmdT expected, input dbiCmdT actual);
		if (actual !== expected)
		begin
			cmdErrors++;
			$display("ERROR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkPos(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		if (actual !== expected)
		begin
			posErrors++;
			$display("ERROR %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkLevel(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			otherErrors++;
			$display("ERROR %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic idleGap();
		int gap;
		gap = $random(seed) & 3;
		repeat (gap) @(posedge clock);
	endtask

	task automatic sendPixel(input colorInT c);
		@(posedge clock);
		pixValid <= 1'b1;
		pixIn    <= c;
		do
			@(negedge clock);
		while (!pixReady);  // Transfer on the next rising edge
		@(posedge clock);
		pixValid <= 1'b0;
	endtask

	task automatic writeCmd(input dbiCmdT c);
		@(posedge clock);
		cmdCyc <= 1'b1;
		cmdStb <= 1'b1;
		cmdWe  <= 1'b1;
		cmdDat <= c;
		do
			@(negedge clock);
		while (!cmdAck);
		@(posedge clock);
		cmdCyc <= 1'b0;
		cmdStb <= 1'b0;
		cmdWe  <= 1'b0;
	endtask

	task automatic streamPixels();
		for (int i = 0; i < PIX_N; i++)
		begin
			sendPixel(pixStim[i]);
			idleGap();
		end
	endtask

	task automatic streamCmds();
		for (int j = 0; j < CMD_N; j++)
		begin
			writeCmd(cmdStim[j]);
			idleGap();
		end
	endtask

	task automatic waitWords(input int pairs, input int cmds);
		while (pixQ.size() < pairs || cmdQ.size() < cmds)
			@(posedge clock);
	endtask

	// Panel-side decoder, bits taken where SCL has just risen
	always @(negedge clock)
	begin
		if (sclL && !sclPrev && !csNL)
		begin
			if (nBits == 0)
			begin
				wordDc  = dcL;
				wordDcR = dcR;
			end
			curL = {curL[PIX_BITS-2:0], sdaL};
			curR = {curR[PIX_BITS-2:0], sdaR};
			nBits++;
			// Table pairs differ in their top byte so equal lanes here mean a command
			if (nBits == CMD_BITS && curL[CMD_BITS-1:0] == curR[CMD_BITS-1:0])
			begin
				checkLevel("right DC of command", cmdStim[cmdQ.size() % CMD_N].isData,
					wordDcR);
				cmdQ.push_back({wordDc, curL[CMD_BITS-1:0]});
				cmdDoneMark.push_back(pairCount);
				nBits = 0;
			end
			else if (nBits == PIX_BITS)
			begin
				checkLevel("left DC of pair", 1'b1, wordDc);
				checkLevel("right DC of pair", 1'b1, wordDcR);
				pixQ.push_back({curL, curR});
				pairCount++;
				nBits = 0;
			end
		end
		if (csNL && nBits != 0)
		begin
			otherErrors++;
			$display("panel select went high after only %0d bits of a word", nBits);
			nBits = 0;
		end
		if (cmdAck)
			cmdWriteMark.push_back(pairCount);
		if (frameEnd)
		begin
			frameCount++;
			checkPos("x at frame end", '0, pixPosX);
			checkPos("y at frame end", '0, pixPosY);
		end
		sclPrev = sclL;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < LIMIT)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles while waiting for the DUT", LIMIT);
		$display("test failed");
		$finish;
	end

	initial
	begin
		rstN     = 1'b0;
		pixValid = 1'b0;
		pixIn    = '0;
		cmdCyc   = 1'b0;
		cmdStb   = 1'b0;
		cmdWe    = 1'b0;
		cmdDat   = '0;

		repeat (15) @(posedge clock);
		@(negedge clock);
		checkLevel("csNL in reset", 1'b1, csNL);
		checkLevel("csNR in reset", 1'b1, csNR);
		checkLevel("sclL in reset", 1'b0, sclL);
		checkLevel("sclR in reset", 1'b0, sclR);
		checkLevel("frameEnd in reset", 1'b0, frameEnd);
		checkLevel("resN in reset", 1'b0, resN);
		checkPos("x in reset", '0, pixPosX);
		checkPos("y in reset", '0, pixPosY);
		@(posedge clock);
		rstN <= 1'b1;  // Sixteenth edge with reset low
		@(negedge clock);
		checkLevel("resN as rstN rises", 1'b0, resN);
		@(negedge clock);
		checkLevel("resN one clock later", 1'b1, resN);

		streamCmds();
		waitWords(0, CMD_N);
		streamPixels();
		waitWords(PIX_N / 2, CMD_N);

		// Commands land while pairs wait in the pixel buffer
		fork
			streamPixels();
			begin
				repeat (30) @(posedge clock);
				streamCmds();
			end
		join
		waitWords(TOTAL_PAIRS, 2 * CMD_N);
		repeat (4) @(negedge clock);

		if (pixQ.size() != TOTAL_PAIRS || cmdQ.size() != 2 * CMD_N)
		begin
			otherErrors++;
			$display("decoded %0d pairs and %0d commands but expected %0d and %0d",
				pixQ.size(), cmdQ.size(), TOTAL_PAIRS, 2 * CMD_N);
		end
		for (int k = 0; k < TOTAL_PAIRS; k++)
		begin
			checkPixel(pixTag[(2 * k) % PIX_N], pixExp[(2 * k) % PIX_N], pixQ[k].even);
			checkPixel(pixTag[(2 * k + 1) % PIX_N], pixExp[(2 * k + 1) % PIX_N], pixQ[k].odd);
		end
		for (int j = 0; j < 2 * CMD_N; j++)
		begin
			checkCmd($sformatf("command %0d", j), cmdStim[j % CMD_N], cmdQ[j]);
			if (cmdDoneMark[j] > cmdWriteMark[j] + 1)
			begin
				otherErrors++;
				$display("command %0d went out after %0d pairs but was written after %0d",
					j, cmdDoneMark[j], cmdWriteMark[j]);
			end
		end
		checkPos("final x", 12'(TOTAL_PAIRS % PANEL_WIDTH), pixPosX);
		checkPos("final y", 12'((TOTAL_PAIRS / PANEL_WIDTH) % PANEL_HEIGHT), pixPosY);
		if (frameCount != TOTAL_PAIRS / (PANEL_WIDTH * PANEL_HEIGHT))
		begin
			otherErrors++;
			$display("ERROR frame count expected %0d actual %0d",
				TOTAL_PAIRS / (PANEL_WIDTH * PANEL_HEIGHT), frameCount);
		end
		otherErrors += dut.serializer.linkChecks.failures;

		$display("errors: pixel %0d, command %0d, position %0d, other %0d",
			pixErrors, cmdErrors, posErrors, otherErrors);
		if (pixErrors + cmdErrors + posErrors + otherErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* lcdDbiPair.f */
hw/lcdPixelPkg.sv
hw/lcdLinkPkg.sv
hw/pixelPairer.sv
hw/wbFifo.sv
hw/dbiSerializer.sv
hw/lcdDbiPair.sv
tb/lcdDbiPair_checker.sv
tb/lcdDbiPair_tb.sv

/* Bender.yml */
package:
  name: lcdDbiPair

sources:
  # Packages first, then the blocks bottom-up
  - hw/lcdPixelPkg.sv
  - hw/lcdLinkPkg.sv
  - hw/pixelPairer.sv
  - hw/wbFifo.sv
  - hw/dbiSerializer.sv
  - hw/lcdDbiPair.sv
  - target: test
    files:
      - tb/lcdDbiPair_checker.sv
      - tb/lcdDbiPair_tb.sv
